// File: common/hps_pkg.sv
// shared widths, command codes and the configuration string for the host command endpoint
`default_nettype none

package hps_pkg;

	//////////////////////////////
	// bus and register widths

	typedef logic [15:0]  io_word_t;
	typedef logic [15:0]  cmd_t;
	// word counter within one command, saturates at all ones
	typedef logic [5:0]   byte_cnt_t;
	typedef logic [31:0]  joy_t;
	typedef logic [127:0] status_t;
	typedef logic [26:0]  ioctl_addr_t;
	typedef logic [7:0]   ioctl_byte_t;

	typedef enum logic [0:0] {
		FIO_WAIT_CMD = 1'b0,
		FIO_ARGS     = 1'b1
	} fio_phase_e;

	//////////////////////////////
	// user I/O commands

	localparam cmd_t CMD_CFG        = 16'h0001;
	localparam cmd_t CMD_JOY0       = 16'h0002;
	localparam cmd_t CMD_JOY1       = 16'h0003;
	localparam cmd_t CMD_JOY2       = 16'h0010;
	localparam cmd_t CMD_JOY3       = 16'h0011;
	localparam cmd_t CMD_JOY_RAW    = 16'h000F;
	localparam cmd_t CMD_CONF_STR   = 16'h0014;
	localparam cmd_t CMD_STATUS     = 16'h001E;
	localparam cmd_t CMD_STATUS_REQ = 16'h0029;
	localparam cmd_t CMD_MENUMASK   = 16'h002E;
	localparam cmd_t CMD_SDRAM_SZ   = 16'h0031;

	//////////////////////////////
	// file channel commands

	localparam cmd_t FIO_FILE_TX     = 16'h0053;
	localparam cmd_t FIO_FILE_TX_DAT = 16'h0054;
	localparam cmd_t FIO_FILE_INDEX  = 16'h0055;
	localparam cmd_t FIO_FILE_INFO   = 16'h0056;

	// heads the reply to a status request
	localparam logic [3:0] STATUS_REQ_TAG = 4'hA;

	// menu description handed to the host, first character in the top byte
	localparam int CONF_STRLEN = 48;
	localparam logic [CONF_STRLEN*8-1:0] CONF_STR =
		"DEMO;;O12,Scanlines,Off,25%,50%;T0,Reset;V,v1.00";

	// one ROM entry per counter value, so every address is defined
	localparam int CONF_ROM_DEPTH = 2 ** $bits(byte_cnt_t);

endpackage

`default_nettype wire

// File: dv/hps_io_checker.sv
// testbench checker; follows the host bus traffic, predicts replies, registers and writes, counts errors
`timescale 1ns/1ns
`default_nettype none

module hps_io_checker (
	input  logic                 clk_sys,
	input  logic                 rst,
	input  int                   test_phase,
	input  logic                 io_enable,
	input  logic                 fp_enable,
	input  logic                 io_strobe,
	input  hps_pkg::io_word_t    io_din,
	input  hps_pkg::io_word_t    io_dout,
	input  hps_pkg::io_word_t    joy_raw,
	input  hps_pkg::status_t     status_in,
	input  logic                 status_set,
	input  hps_pkg::io_word_t    status_menumask,
	input  logic [1:0]           buttons,
	input  logic                 forced_scandoubler,
	input  logic                 direct_video,
	input  hps_pkg::joy_t        joystick_0,
	input  hps_pkg::joy_t        joystick_1,
	input  hps_pkg::joy_t        joystick_2,
	input  hps_pkg::joy_t        joystick_3,
	input  hps_pkg::status_t     status,
	input  hps_pkg::io_word_t    sdram_sz,
	input  logic                 ioctl_download,
	input  logic                 ioctl_wr,
	input  hps_pkg::io_word_t    ioctl_index,
	input  hps_pkg::ioctl_addr_t ioctl_addr,
	input  hps_pkg::ioctl_byte_t ioctl_dout,
	input  logic [31:0]          ioctl_file_ext,
	output int                   err_total,
	output int                   chk_total,
	output int                   tests_done,
	output int                   wr_seen
);

	// words of the open frame on each channel, the command first
	hps_pkg::io_word_t    uio_words [$];
	hps_pkg::io_word_t    fio_words [$];
	// expected writes as {address, byte}
	logic [34:0]          exp_wr [$];
	logic [34:0]          wr_item;

	logic                 io_en_q;
	logic                 fp_en_q;
	logic                 set_q;
	logic                 reply_pend;
	int                   reply_idx;
	hps_pkg::io_word_t    reply_exp;
	logic [3:0]           req_cnt;
	hps_pkg::status_t     req_val;
	logic                 dl_active;
	hps_pkg::ioctl_addr_t dl_start;
	int                   dl_count;
	int                   n_err;
	int                   n_chk;
	int                   n_tests;
	int                   n_wr;
	int                   phase_q;
	int                   phase_chk;
	int                   phase_err;

	function automatic string test_name(input int p);
		case (p)
			1: return "cfg_joystick";
			2: return "status_write";
			3: return "conf_string";
			4: return "status_request";
			5: return "readbacks";
			6: return "file_download";
			default: return "idle";
		endcase
	endfunction

	//////////////////////////////
	// reference model

	// {buttons, forced_scandoubler, direct_video}
	function automatic logic [3:0] cfg_decode(input hps_pkg::io_word_t w);
		return {w[1:0], w[4], w[10]};
	endfunction

	// words 1 to 8 of the open frame, low half-word first
	function automatic hps_pkg::status_t status_assemble();
		hps_pkg::status_t s;
		s = '0;
		for (int i = 0; i < 8; i++) begin
			s[i*16 +: 16] = uio_words[i+1];
		end
		return s;
	endfunction

	// word n returns character n-1, zero past the end
	function automatic logic [7:0] conf_str_byte(input int n);
		logic [hps_pkg::CONF_STRLEN*8-1:0] s;
		if (n < 1 || n > hps_pkg::CONF_STRLEN) begin
			return 8'h00;
		end
		s = hps_pkg::CONF_STR >> ((hps_pkg::CONF_STRLEN - n) * 8);
		return s[7:0];
	endfunction

	function automatic hps_pkg::io_word_t req_reply(input int idx, input logic [3:0] cnt,
			input hps_pkg::status_t v);
		if (idx == 0) begin
			return {8'h00, hps_pkg::STATUS_REQ_TAG, cnt};
		end
		if (idx <= 8) begin
			return v[(idx-1)*16 +: 16];
		end
		return 16'h0000;
	endfunction

	function automatic hps_pkg::ioctl_addr_t dl_addr(input hps_pkg::ioctl_addr_t start,
			input int i);
		return start + hps_pkg::ioctl_addr_t'(i);
	endfunction

	function automatic hps_pkg::io_word_t expected_reply(input hps_pkg::cmd_t cmd, input int idx);
		if (cmd == hps_pkg::CMD_STATUS_REQ) begin
			return req_reply(idx, req_cnt, req_val);
		end
		if (idx == 0) begin
			return 16'h0000;
		end
		case (cmd)
			hps_pkg::CMD_MENUMASK: return (idx == 1) ? status_menumask : 16'h0000;
			hps_pkg::CMD_JOY_RAW:  return joy_raw;
			hps_pkg::CMD_CONF_STR: return {8'h00, conf_str_byte(idx)};
			default:               return 16'h0000;
		endcase
	endfunction

	//////////////////////////////
	// comparison and reporting

	task automatic check_val(input string what, input logic [127:0] exp, input logic [127:0] act);
		n_chk++;
		phase_chk++;
		if (exp !== act) begin
			n_err++;
			phase_err++;
			$display("[ERROR] %s %s: expected %0h, actual %0h", test_name(phase_q), what, exp, act);
		end
	endtask

	task automatic report_fault(input string msg);
		n_err++;
		phase_err++;
		$display("%s: %s", test_name(phase_q), msg);
	endtask

	task automatic finish_test();
		if (exp_wr.size() != 0) begin
			report_fault($sformatf("%0d expected write pulses never came", exp_wr.size()));
		end
		exp_wr.delete();
		if (phase_chk == 0) begin
			report_fault("no comparison was made in this test");
		end
		$display("test %-14s %s, %0d checks, %0d errors", test_name(phase_q),
			(phase_err == 0) ? "ok" : "FAILED", phase_chk, phase_err);
		n_tests++;
	endtask

	// register outputs are settled by the time the enable drops
	task automatic finish_uio_frame();
		hps_pkg::cmd_t cmd;
		hps_pkg::joy_t joy_act;
		if (uio_words.size() < 2) begin
			return;
		end
		cmd = uio_words[0];
		joy_act = (cmd == hps_pkg::CMD_JOY0) ? joystick_0 :
			(cmd == hps_pkg::CMD_JOY1) ? joystick_1 :
			(cmd == hps_pkg::CMD_JOY2) ? joystick_2 : joystick_3;
		case (cmd)
			hps_pkg::CMD_CFG: check_val("config outputs", 128'(cfg_decode(uio_words[1])),
				128'({buttons, forced_scandoubler, direct_video}));
			hps_pkg::CMD_JOY0, hps_pkg::CMD_JOY1, hps_pkg::CMD_JOY2, hps_pkg::CMD_JOY3: begin
				if (uio_words.size() >= 3) begin
					check_val($sformatf("joystick cmd %0h", cmd),
						128'({uio_words[2], uio_words[1]}), 128'(joy_act));
				end
			end
			hps_pkg::CMD_STATUS: begin
				if (uio_words.size() >= 9) begin
					check_val("status", status_assemble(), status);
				end
			end
			hps_pkg::CMD_SDRAM_SZ: check_val("sdram_sz", 128'(uio_words[1]), 128'(sdram_sz));
			default: ;
		endcase
	endtask

	task automatic finish_fio_frame();
		if (fio_words.size() < 2) begin
			return;
		end
		case (fio_words[0])
			hps_pkg::FIO_FILE_INDEX: check_val("ioctl_index", 128'(fio_words[1]), 128'(ioctl_index));
			hps_pkg::FIO_FILE_INFO: begin
				if (fio_words.size() >= 3) begin
					check_val("ioctl_file_ext", 128'({fio_words[1], fio_words[2]}),
						128'(ioctl_file_ext));
				end
			end
			hps_pkg::FIO_FILE_TX: begin
				check_val("ioctl_download", 128'(fio_words[1][7:0] != 8'h00), 128'(ioctl_download));
				if (fio_words[1][7:0] == 8'h00) begin
					check_val("ioctl_addr after stop", 128'(dl_addr(dl_start, dl_count)),
						128'(ioctl_addr));
				end
			end
			default: ;
		endcase
	endtask

	// download bookkeeping as each file word arrives
	task automatic fio_word(input int idx, input hps_pkg::io_word_t w);
		if (idx == 0) begin
			return;
		end
		if (fio_words[0] == hps_pkg::FIO_FILE_TX) begin
			if (idx == 1) begin
				dl_active = (w[7:0] != 8'h00);
				if (dl_active) begin
					dl_start = '0;
					dl_count = 0;
				end
			end else if (idx == 2) begin
				dl_start[15:0] = w;
			end else if (idx == 3) begin
				dl_start[26:16] = w[10:0];
			end
		end else if (fio_words[0] == hps_pkg::FIO_FILE_TX_DAT && dl_active) begin
			exp_wr.push_back({dl_addr(dl_start, dl_count), w[7:0]});
			dl_count++;
		end
	endtask

	//////////////////////////////
	// bus monitor

	always @(posedge clk_sys) begin
		if (rst) begin
			uio_words.delete();
			fio_words.delete();
			exp_wr.delete();
			io_en_q    = 1'b0;
			fp_en_q    = 1'b0;
			set_q      = 1'b0;
			reply_pend = 1'b0;
			req_cnt    = '0;
			req_val    = '0;
			dl_active  = 1'b0;
			dl_start   = '0;
			dl_count   = 0;
		end else begin
			if (test_phase != phase_q) begin
				if (phase_q >= 1 && phase_q <= 6) begin
					finish_test();
				end
				phase_q   = test_phase;
				phase_chk = 0;
				phase_err = 0;
			end

			// reply is due one cycle after its strobe
			if (reply_pend) begin
				check_val($sformatf("reply to word %0d", reply_idx), 128'(reply_exp), 128'(io_dout));
				reply_pend = 1'b0;
			end

			if (!io_enable) begin
				if (io_en_q) begin
					finish_uio_frame();
				end
				uio_words.delete();
			end else if (io_strobe) begin
				uio_words.push_back(io_din);
				reply_idx  = uio_words.size() - 1;
				reply_exp  = expected_reply(uio_words[0], reply_idx);
				reply_pend = 1'b1;
			end
			io_en_q = io_enable;

			if (!fp_enable) begin
				if (fp_en_q) begin
					finish_fio_frame();
				end
				fio_words.delete();
			end else if (io_strobe) begin
				fio_words.push_back(io_din);
				fio_word(fio_words.size() - 1, io_din);
			end
			fp_en_q = fp_enable;

			if (ioctl_wr) begin
				n_wr++;
				if (!ioctl_download) begin
					report_fault("write pulse while no download is open");
				end
				if (exp_wr.size() == 0) begin
					report_fault("write pulse that no data word asked for");
				end else begin
					wr_item = exp_wr.pop_front();
					check_val("write address", 128'(wr_item[34:8]), 128'(ioctl_addr));
					check_val("write byte", 128'(wr_item[7:0]), 128'(ioctl_dout));
				end
			end

			// each rising edge of the request counts and captures
			if (status_set && !set_q) begin
				req_cnt = req_cnt + 4'd1;
				req_val = status_in;
			end
			set_q = status_set;
		end

		err_total  <= n_err;
		chk_total  <= n_chk;
		tests_done <= n_tests;
		wr_seen    <= n_wr;
	end

	initial begin
		n_err   = 0;
		n_chk   = 0;
		n_tests = 0;
		n_wr    = 0;
		phase_q = 0;
	end

endmodule

`default_nettype wire

// File: dv/tb_hps_io.sv
// testbench top; clocks and resets the DUT and drives host command frames on both channels
`timescale 1ns/1ns
`default_nettype none

module tb_hps_io;

	localparam int CLK_PERIOD   = 40;
	localparam int RESET_CYCLES = 5;
	localparam int WAIT_LIMIT   = 5000;
	localparam int N_BYTES      = 24;
	localparam int NUM_TESTS    = 6;

	logic                 clk_sys;
	logic                 rst;
	logic                 io_enable;
	logic                 fp_enable;
	logic                 io_strobe;
	hps_pkg::io_word_t    io_din;
	hps_pkg::io_word_t    io_dout;
	hps_pkg::io_word_t    joy_raw;
	hps_pkg::status_t     status_in;
	logic                 status_set;
	hps_pkg::io_word_t    status_menumask;
	logic [1:0]           buttons;
	logic                 forced_scandoubler;
	logic                 direct_video;
	hps_pkg::joy_t        joystick_0;
	hps_pkg::joy_t        joystick_1;
	hps_pkg::joy_t        joystick_2;
	hps_pkg::joy_t        joystick_3;
	hps_pkg::status_t     status;
	hps_pkg::io_word_t    sdram_sz;
	logic                 ioctl_download;
	logic                 ioctl_wr;
	hps_pkg::io_word_t    ioctl_index;
	hps_pkg::ioctl_addr_t ioctl_addr;
	hps_pkg::ioctl_byte_t ioctl_dout;
	logic [31:0]          ioctl_file_ext;

	int                   test_phase;
	int                   err_total;
	int                   chk_total;
	int                   tests_done;
	int                   wr_seen;
	int                   seed;
	logic                 timed_out;
	hps_pkg::io_word_t    arg_q [$];
	logic [31:0]          start_addr;

	hps_io i_dut (
		.clk_sys (clk_sys), .rst (rst), .io_enable (io_enable), .fp_enable (fp_enable),
		.io_strobe (io_strobe), .io_din (io_din), .io_dout (io_dout),
		.joy_raw (joy_raw), .status_in (status_in), .status_set (status_set),
		.status_menumask (status_menumask), .buttons (buttons),
		.forced_scandoubler (forced_scandoubler), .direct_video (direct_video),
		.joystick_0 (joystick_0), .joystick_1 (joystick_1), .joystick_2 (joystick_2),
		.joystick_3 (joystick_3), .status (status), .sdram_sz (sdram_sz),
		.ioctl_download (ioctl_download), .ioctl_wr (ioctl_wr), .ioctl_index (ioctl_index),
		.ioctl_addr (ioctl_addr), .ioctl_dout (ioctl_dout), .ioctl_file_ext (ioctl_file_ext)
	);

	hps_io_checker i_checker (
		.clk_sys (clk_sys), .rst (rst), .test_phase (test_phase), .io_enable (io_enable),
		.fp_enable (fp_enable), .io_strobe (io_strobe), .io_din (io_din), .io_dout (io_dout),
		.joy_raw (joy_raw), .status_in (status_in), .status_set (status_set),
		.status_menumask (status_menumask), .buttons (buttons),
		.forced_scandoubler (forced_scandoubler), .direct_video (direct_video),
		.joystick_0 (joystick_0), .joystick_1 (joystick_1), .joystick_2 (joystick_2),
		.joystick_3 (joystick_3), .status (status), .sdram_sz (sdram_sz),
		.ioctl_download (ioctl_download), .ioctl_wr (ioctl_wr), .ioctl_index (ioctl_index),
		.ioctl_addr (ioctl_addr), .ioctl_dout (ioctl_dout), .ioctl_file_ext (ioctl_file_ext),
		.err_total (err_total), .chk_total (chk_total), .tests_done (tests_done),
		.wr_seen (wr_seen)
	);

	initial begin
		clk_sys = 1'b0;
		forever #(CLK_PERIOD / 2) clk_sys = ~clk_sys;
	end

	function automatic logic [31:0] rand32();
		return $random(seed);
	endfunction

	function automatic hps_pkg::io_word_t rand_word();
		logic [31:0] r;
		r = rand32();
		return r[15:0];
	endfunction

	// strobes land three cycles apart
	task automatic strobe_word(input hps_pkg::io_word_t w);
		@(posedge clk_sys);
		io_din    <= w;
		io_strobe <= 1'b1;
		@(posedge clk_sys);
		io_strobe <= 1'b0;
		@(posedge clk_sys);
	endtask

	// one framed command with its arguments from arg_q
	task automatic send_frame(input logic file_ch, input hps_pkg::cmd_t cmd);
		@(posedge clk_sys);
		if (file_ch) begin
			fp_enable <= 1'b1;
		end else begin
			io_enable <= 1'b1;
		end
		strobe_word(cmd);
		foreach (arg_q[i]) begin
			strobe_word(arg_q[i]);
		end
		@(posedge clk_sys);
		io_enable <= 1'b0;
		fp_enable <= 1'b0;
		repeat (2) @(posedge clk_sys);
	endtask

	task automatic random_args(input int n);
		arg_q.delete();
		repeat (n) arg_q.push_back(rand_word());
	endtask

	task automatic pulse_status_set();
		@(posedge clk_sys);
		status_in  <= {rand32(), rand32(), rand32(), rand32()};
		status_set <= 1'b1;
		@(posedge clk_sys);
		status_set <= 1'b0;
		@(posedge clk_sys);
	endtask

	task automatic begin_test(input int p);
		repeat (4) @(posedge clk_sys);
		test_phase <= p;
	endtask

	task automatic wait_writes(input int target);
		int cycles;
		cycles = 0;
		while (wr_seen < target && cycles < WAIT_LIMIT) begin
			@(posedge clk_sys);
			cycles++;
		end
		if (wr_seen < target) begin
			$display("timeout with %0d of %0d write pulses seen", wr_seen, target);
			timed_out = 1'b1;
		end
	endtask

	task automatic wait_reports(input int target);
		int cycles;
		cycles = 0;
		while (tests_done < target && cycles < WAIT_LIMIT) begin
			@(posedge clk_sys);
			cycles++;
		end
		if (tests_done < target) begin
			$display("timeout with %0d of %0d test reports seen", tests_done, target);
			timed_out = 1'b1;
		end
	endtask

	initial begin
		seed            = 32'hf3093a1a;
		timed_out       = 1'b0;
		rst             = 1'b1;
		io_enable       = 1'b0;
		fp_enable       = 1'b0;
		io_strobe       = 1'b0;
		io_din          = '0;
		joy_raw         = '0;
		status_in       = '0;
		status_set      = 1'b0;
		status_menumask = '0;
		test_phase      = 0;
		repeat (RESET_CYCLES) @(posedge clk_sys);
		rst <= 1'b0;

		begin_test(1);
		random_args(1);
		send_frame(1'b0, hps_pkg::CMD_CFG);
		random_args(2);
		send_frame(1'b0, hps_pkg::CMD_JOY0);
		random_args(2);
		send_frame(1'b0, hps_pkg::CMD_JOY1);
		random_args(2);
		send_frame(1'b0, hps_pkg::CMD_JOY2);
		random_args(2);
		send_frame(1'b0, hps_pkg::CMD_JOY3);

		begin_test(2);
		random_args(8);
		send_frame(1'b0, hps_pkg::CMD_STATUS);

		// two words past the end read zero
		begin_test(3);
		random_args(hps_pkg::CONF_STRLEN + 2);
		send_frame(1'b0, hps_pkg::CMD_CONF_STR);

		// enough edges to wrap the 4-bit counter
		begin_test(4);
		repeat (17 + (rand32() & 32'd7)) pulse_status_set();
		random_args(8);
		send_frame(1'b0, hps_pkg::CMD_STATUS_REQ);

		begin_test(5);
		@(posedge clk_sys);
		joy_raw         <= rand_word();
		status_menumask <= rand_word();
		random_args(1);
		send_frame(1'b0, hps_pkg::CMD_MENUMASK);
		random_args(2);
		send_frame(1'b0, hps_pkg::CMD_JOY_RAW);
		random_args(1);
		send_frame(1'b0, hps_pkg::CMD_SDRAM_SZ);

		begin_test(6);
		random_args(1);
		send_frame(1'b1, hps_pkg::FIO_FILE_INDEX);
		random_args(2);
		send_frame(1'b1, hps_pkg::FIO_FILE_INFO);
		start_addr = rand32();
		arg_q.delete();
		arg_q.push_back(16'h0001);
		arg_q.push_back(start_addr[15:0]);
		arg_q.push_back({5'd0, start_addr[26:16]});
		send_frame(1'b1, hps_pkg::FIO_FILE_TX);
		random_args(N_BYTES);
		send_frame(1'b1, hps_pkg::FIO_FILE_TX_DAT);
		wait_writes(N_BYTES);
		if (!timed_out) begin
			arg_q.delete();
			arg_q.push_back(16'h0000);
			send_frame(1'b1, hps_pkg::FIO_FILE_TX);
			// data with no open download
			random_args(4);
			send_frame(1'b1, hps_pkg::FIO_FILE_TX_DAT);

			begin_test(NUM_TESTS + 1);
			wait_reports(NUM_TESTS);
		end

		$display("tests %0d, checks %0d, errors %0d", tests_done, chk_total, err_total);
		if (!timed_out && err_total == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: fio/fio_loader.sv
// file channel decoder; turns host download commands into core byte writes
`timescale 1ns/1ns
`default_nettype none

module fio_loader (
	input  logic                 clk_sys,
	input  logic                 rst,
	input  logic                 fp_enable,
	input  logic                 io_strobe,
	input  hps_pkg::io_word_t    io_din,

	output logic                 ioctl_download,
	output logic                 ioctl_wr,
	output hps_pkg::io_word_t    ioctl_index,
	output hps_pkg::ioctl_addr_t ioctl_addr,
	output hps_pkg::ioctl_byte_t ioctl_dout,
	output logic [31:0]          ioctl_file_ext
);

	hps_pkg::fio_phase_e  phase;
	hps_pkg::cmd_t        cmd;
	// argument index, word 1 is zero, sticks at 3
	logic [1:0]           arg_cnt;
	// next byte address of the download
	hps_pkg::ioctl_addr_t addr;
	logic                 wr_pend;

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			phase          <= hps_pkg::FIO_WAIT_CMD;
			cmd            <= '0;
			arg_cnt        <= '0;
			addr           <= '0;
			wr_pend        <= 1'b0;
			ioctl_wr       <= 1'b0;
			ioctl_download <= 1'b0;
			ioctl_index    <= '0;
			ioctl_addr     <= '0;
			ioctl_dout     <= '0;
			ioctl_file_ext <= '0;
		end else begin
			// write strobe lags the data by one cycle
			ioctl_wr <= wr_pend;
			wr_pend  <= 1'b0;

			if (!fp_enable) begin
				phase <= hps_pkg::FIO_WAIT_CMD;
			end else if (io_strobe) begin
				case (phase)
					hps_pkg::FIO_WAIT_CMD: begin
						cmd     <= io_din;
						arg_cnt <= '0;
						phase   <= hps_pkg::FIO_ARGS;
					end

					hps_pkg::FIO_ARGS: begin
						if (arg_cnt != 2'd3) begin
							arg_cnt <= arg_cnt + 2'd1;
						end

						case (cmd)
							// extension, high half first
							hps_pkg::FIO_FILE_INFO: begin
								case (arg_cnt)
									2'd0: ioctl_file_ext[31:16] <= io_din;
									2'd1: ioctl_file_ext[15:0] <= io_din;
									default: ;
								endcase
							end

							hps_pkg::FIO_FILE_INDEX: ioctl_index <= io_din;

							hps_pkg::FIO_FILE_TX: begin
								case (arg_cnt)
									2'd0: begin
										if (io_din[7:0] != 8'h00) begin
											addr           <= '0;
											ioctl_download <= 1'b1;
										end else begin
											// park on the next unwritten byte
											if (ioctl_download) begin
												ioctl_addr <= addr;
											end
											ioctl_download <= 1'b0;
										end
									end
									2'd1: begin
										ioctl_addr[15:0] <= io_din;
										addr[15:0]       <= io_din;
									end
									2'd2: begin
										ioctl_addr[26:16] <= io_din[10:0];
										addr[26:16]       <= io_din[10:0];
									end
									default: ;
								endcase
							end

							// bytes outside a download are dropped
							hps_pkg::FIO_FILE_TX_DAT: begin
								if (ioctl_download) begin
									ioctl_addr <= addr;
									ioctl_dout <= io_din[7:0];
									wr_pend    <= 1'b1;
									addr       <= addr + 27'd1;
								end
							end

							default: ;
						endcase
					end

					default: phase <= hps_pkg::FIO_WAIT_CMD;
				endcase
			end
		end
	end

	// a write may only land inside an open download
	a_wr_in_download: assert property (@(posedge clk_sys) disable iff (rst)
		ioctl_wr |-> ioctl_download);

endmodule

`default_nettype wire

// File: hdl/hps_io.sv
// host command endpoint top; sits between the host strobed I/O bus and the emulated core
`timescale 1ns/1ns
`default_nettype none

module hps_io (
	input  logic                 clk_sys,
	input  logic                 rst,
	input  logic                 io_enable,
	input  logic                 fp_enable,
	input  logic                 io_strobe,
	input  hps_pkg::io_word_t    io_din,
	output hps_pkg::io_word_t    io_dout,

	input  hps_pkg::io_word_t    joy_raw,
	input  hps_pkg::status_t     status_in,
	input  logic                 status_set,
	input  hps_pkg::io_word_t    status_menumask,

	output logic [1:0]           buttons,
	output logic                 forced_scandoubler,
	output logic                 direct_video,
	output hps_pkg::joy_t        joystick_0,
	output hps_pkg::joy_t        joystick_1,
	output hps_pkg::joy_t        joystick_2,
	output hps_pkg::joy_t        joystick_3,
	output hps_pkg::status_t     status,
	output hps_pkg::io_word_t    sdram_sz,

	output logic                 ioctl_download,
	output logic                 ioctl_wr,
	output hps_pkg::io_word_t    ioctl_index,
	output hps_pkg::ioctl_addr_t ioctl_addr,
	output hps_pkg::ioctl_byte_t ioctl_dout,
	output logic [31:0]          ioctl_file_ext
);

	hps_pkg::io_word_t uio_dout;

	// file channel has nothing to read back
	assign io_dout = fp_enable ? '0 : uio_dout;

	uio_regs i_uio_regs (
		.clk_sys            (clk_sys),
		.rst                (rst),
		.io_enable          (io_enable),
		.io_strobe          (io_strobe),
		.io_din             (io_din),
		.io_dout            (uio_dout),
		.joy_raw            (joy_raw),
		.status_in          (status_in),
		.status_set         (status_set),
		.status_menumask    (status_menumask),
		.buttons            (buttons),
		.forced_scandoubler (forced_scandoubler),
		.direct_video       (direct_video),
		.joystick_0         (joystick_0),
		.joystick_1         (joystick_1),
		.joystick_2         (joystick_2),
		.joystick_3         (joystick_3),
		.status             (status),
		.sdram_sz           (sdram_sz)
	);

	fio_loader i_fio_loader (
		.clk_sys        (clk_sys),
		.rst            (rst),
		.fp_enable      (fp_enable),
		.io_strobe      (io_strobe),
		.io_din         (io_din),
		.ioctl_download (ioctl_download),
		.ioctl_wr       (ioctl_wr),
		.ioctl_index    (ioctl_index),
		.ioctl_addr     (ioctl_addr),
		.ioctl_dout     (ioctl_dout),
		.ioctl_file_ext (ioctl_file_ext)
	);

endmodule

`default_nettype wire

// File: hps_io.f
common/hps_pkg.sv
uio/confstr_rom.sv
uio/uio_regs.sv
fio/fio_loader.sv
hdl/hps_io.sv
dv/hps_io_checker.sv
dv/tb_hps_io.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the hps_io testbench with Verilator, runs it, and passes only on the pass line.
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timing -j 0 \
	--top-module tb_hps_io \
	--Mdir obj_dir \
	-f hps_io.f
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

sim_out="$(./obj_dir/Vtb_hps_io)"
sim_status=$?
printf '%s\n' "$sim_out"

if [ $sim_status -ne 0 ]; then
	echo "simulation exited with status $sim_status"
	exit 1
fi

if printf '%s\n' "$sim_out" | grep -qx "Testbench passed"; then
	exit 0
fi

echo "pass line not found in simulation output"
exit 1

// File: uio/confstr_rom.sv
// configuration string ROM; returns one string byte per address with one cycle of latency
`timescale 1ns/1ns
`default_nettype none

module confstr_rom (
	input  logic               clk_sys,
	input  hps_pkg::byte_cnt_t conf_addr,
	output logic [7:0]         conf_byte
);

	logic [7:0] rom [hps_pkg::CONF_ROM_DEPTH];

	// first character is the top byte of the literal, tail of the ROM reads zero
	initial begin
		for (int i = 0; i < hps_pkg::CONF_ROM_DEPTH; i++) begin
			if (i < hps_pkg::CONF_STRLEN) begin
				rom[i] = hps_pkg::CONF_STR[(hps_pkg::CONF_STRLEN - i) * 8 - 1 -: 8];
			end else begin
				rom[i] = 8'h00;
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		conf_byte <= rom[conf_addr];
	end

endmodule

`default_nettype wire

// File: uio/uio_regs.sv
// user I/O command decoder; holds the core control registers and answers host readbacks
`timescale 1ns/1ns
`default_nettype none

module uio_regs (
	input  logic               clk_sys,
	input  logic               rst,
	input  logic               io_enable,
	input  logic               io_strobe,
	input  hps_pkg::io_word_t  io_din,
	output hps_pkg::io_word_t  io_dout,

	input  hps_pkg::io_word_t  joy_raw,
	input  hps_pkg::status_t   status_in,
	input  logic               status_set,
	input  hps_pkg::io_word_t  status_menumask,

	output logic [1:0]         buttons,
	output logic               forced_scandoubler,
	output logic               direct_video,
	output hps_pkg::joy_t      joystick_0,
	output hps_pkg::joy_t      joystick_1,
	output hps_pkg::joy_t      joystick_2,
	output hps_pkg::joy_t      joystick_3,
	output hps_pkg::status_t   status,
	output hps_pkg::io_word_t  sdram_sz
);

	hps_pkg::cmd_t       cmd;
	hps_pkg::byte_cnt_t  byte_cnt;
	hps_pkg::byte_cnt_t  word_idx;
	hps_pkg::io_word_t   cfg;
	hps_pkg::joy_t       joy_q [4];
	logic [1:0]          joy_sel;
	logic                status_word;
	logic [7:0]          conf_byte;

	logic                status_set_q;
	logic [3:0]          req_cnt;
	hps_pkg::status_t    req_status;

	// config word bits, the others are handled outside the core
	assign buttons            = cfg[1:0];
	assign forced_scandoubler = cfg[4];
	assign direct_video       = cfg[10];

	assign joystick_0 = joy_q[0];
	assign joystick_1 = joy_q[1];
	assign joystick_2 = joy_q[2];
	assign joystick_3 = joy_q[3];

	// 0x02, 0x03, 0x10, 0x11 map onto bits 4 and 0
	assign joy_sel = {cmd[4], cmd[0]};

	// argument index, word 1 is index 0
	assign word_idx    = byte_cnt - 6'd1;
	assign status_word = (word_idx < 6'd8);

	// string byte n-1 is ready by the strobe of word n
	confstr_rom i_confstr_rom (
		.clk_sys   (clk_sys),
		.conf_addr (word_idx),
		.conf_byte (conf_byte)
	);

	//////////////////////////////
	// status set request capture

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			status_set_q <= 1'b0;
			req_cnt      <= '0;
			req_status   <= '0;
		end else begin
			status_set_q <= status_set;
			if (status_set && !status_set_q) begin
				req_cnt    <= req_cnt + 4'd1;
				req_status <= status_in;
			end
		end
	end

	//////////////////////////////
	// command decode

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			cmd      <= '0;
			byte_cnt <= '0;
			io_dout  <= '0;
			cfg      <= '0;
			status   <= '0;
			sdram_sz <= '0;
			for (int i = 0; i < 4; i++) begin
				joy_q[i] <= '0;
			end
		end else if (!io_enable) begin
			// abort, next strobe is a new command
			cmd      <= '0;
			byte_cnt <= '0;
			io_dout  <= '0;
		end else if (io_strobe) begin
			io_dout <= '0;
			if (~&byte_cnt) begin
				byte_cnt <= byte_cnt + 6'd1;
			end

			if (byte_cnt == '0) begin
				cmd <= io_din;
				if (io_din == hps_pkg::CMD_STATUS_REQ) begin
					io_dout <= {8'h00, hps_pkg::STATUS_REQ_TAG, req_cnt};
				end
			end else begin
				case (cmd)
					hps_pkg::CMD_CFG: cfg <= io_din;

					hps_pkg::CMD_JOY0, hps_pkg::CMD_JOY1,
					hps_pkg::CMD_JOY2, hps_pkg::CMD_JOY3: begin
						if (byte_cnt == 6'd1) begin
							joy_q[joy_sel][15:0] <= io_din;
						end else begin
							joy_q[joy_sel][31:16] <= io_din;
						end
					end

					// low half-word first
					hps_pkg::CMD_STATUS: begin
						if (status_word) begin
							status[{word_idx[2:0], 4'h0} +: 16] <= io_din;
						end
					end

					hps_pkg::CMD_STATUS_REQ: begin
						if (status_word) begin
							io_dout <= req_status[{word_idx[2:0], 4'h0} +: 16];
						end
					end

					hps_pkg::CMD_MENUMASK: begin
						if (byte_cnt == 6'd1) begin
							io_dout <= status_menumask;
						end
					end

					hps_pkg::CMD_JOY_RAW: io_dout <= joy_raw;

					// zero once past the end of the string
					hps_pkg::CMD_CONF_STR: begin
						if (byte_cnt <= hps_pkg::byte_cnt_t'(hps_pkg::CONF_STRLEN)) begin
							io_dout <= {8'h00, conf_byte};
						end
					end

					hps_pkg::CMD_SDRAM_SZ: begin
						if (byte_cnt == 6'd1) begin
							sdram_sz <= io_din;
						end
					end

					default: ;
				endcase
			end
		end
	end

	//////////////////////////////
	// host protocol checks

	// the ROM needs the spare cycle between strobes
	a_strobe_spacing: assert property (@(posedge clk_sys) disable iff (rst)
		io_strobe |=> !io_strobe);

	a_cnt_no_wrap: assert property (@(posedge clk_sys) disable iff (rst)
		(io_enable && byte_cnt != '0) |=> (byte_cnt != '0));

endmodule

`default_nettype wire
